/* hnet.f */
src/hnet_pkg.sv
src/hnet_range_cfg.sv
src/hnet_split_1to2.sv
src/hnet_traffic_1to2.sv
src/hnet_top.sv
verification/hnet_tb_clock.sv
verification/hnet_tb_checker.sv
verification/hnet_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the hnet testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module hnet_tb -Mdir obj_dir -f hnet.f

# The pass line decides the result, even if the simulator exits early
sim_out=$(./obj_dir/Vhnet_tb || true)
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx 'Done: no errors'

/* src/hnet_pkg.sv */
`default_nettype none

package hnet_pkg;

	// Message field widths
	localparam int ASZ = 8;
	localparam int DSZ = 16;

	// Configuration register map
	localparam int CFG_AW = 3;
	localparam logic [CFG_AW-1:0] CFG_OPER_1   = 3'd0;
	localparam logic [CFG_AW-1:0] CFG_REF_1    = 3'd1;
	localparam logic [CFG_AW-1:0] CFG_OPER_2   = 3'd2;
	localparam logic [CFG_AW-1:0] CFG_REF_2    = 3'd3;
	localparam logic [CFG_AW-1:0] CFG_IS_RANGE = 3'd4;

	typedef enum logic [2:0] {
		CMP_EQ = 3'd0,
		CMP_NE = 3'd1,
		CMP_GT = 3'd2,
		CMP_GE = 3'd3,
		CMP_LT = 3'd4,
		CMP_LE = 3'd5
	} cmp_op_t;

	// Single comparison, unknown codes never match
	function automatic logic cmp_one(input logic [ASZ-1:0] addr, input cmp_op_t op,
			input logic [ASZ-1:0] ref_val);
		case (op)
			CMP_EQ:  return addr == ref_val;
			CMP_NE:  return addr != ref_val;
			CMP_GT:  return addr > ref_val;
			CMP_GE:  return addr >= ref_val;
			CMP_LT:  return addr < ref_val;
			CMP_LE:  return addr <= ref_val;
			default: return 1'b0;
		endcase
	endfunction

	// Range mode needs both comparisons to hold
	function automatic logic range_match(input logic [ASZ-1:0] addr, input logic is_range,
			input cmp_op_t op_1, input logic [ASZ-1:0] ref_1,
			input cmp_op_t op_2, input logic [ASZ-1:0] ref_2);
		return cmp_one(addr, op_1, ref_1) && (!is_range || cmp_one(addr, op_2, ref_2));
	endfunction

endpackage

`default_nettype wire

/* src/hnet_range_cfg.sv */
`default_nettype none

module hnet_range_cfg (
	input  wire                            i_clk,
	input  wire                            i_rst_n,
	input  wire                            i_cfg_we,
	input  wire [hnet_pkg::CFG_AW-1:0]     i_cfg_addr,
	input  wire [hnet_pkg::ASZ-1:0]        i_cfg_wdata,
	input  wire                            i_run,
	// Live settings for the splitter
	output hnet_pkg::cmp_op_t              o_oper_1,
	output logic [hnet_pkg::ASZ-1:0]       o_ref_1,
	output hnet_pkg::cmp_op_t              o_oper_2,
	output logic [hnet_pkg::ASZ-1:0]       o_ref_2,
	output logic                           o_is_range,
	// Copy taken when traffic starts
	output hnet_pkg::cmp_op_t              o_snap_oper_1,
	output logic [hnet_pkg::ASZ-1:0]       o_snap_ref_1,
	output hnet_pkg::cmp_op_t              o_snap_oper_2,
	output logic [hnet_pkg::ASZ-1:0]       o_snap_ref_2,
	output logic                           o_snap_is_range
);
	import hnet_pkg::*;

	logic r_run_d;

	// Register writes, visible on the next cycle
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_oper_1   <= CMP_GT;
			o_ref_1    <= '0;
			o_oper_2   <= CMP_GT;
			o_ref_2    <= '0;
			o_is_range <= 1'b0;
		end else if (i_cfg_we) begin
			case (i_cfg_addr)
				CFG_OPER_1:   o_oper_1   <= cmp_op_t'(i_cfg_wdata[2:0]);
				CFG_REF_1:    o_ref_1    <= i_cfg_wdata;
				CFG_OPER_2:   o_oper_2   <= cmp_op_t'(i_cfg_wdata[2:0]);
				CFG_REF_2:    o_ref_2    <= i_cfg_wdata;
				CFG_IS_RANGE: o_is_range <= i_cfg_wdata[0];
				default: ;
			endcase
		end
	end

	// Snapshot on the rising edge of run
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			r_run_d         <= 1'b0;
			o_snap_oper_1   <= CMP_GT;
			o_snap_ref_1    <= '0;
			o_snap_oper_2   <= CMP_GT;
			o_snap_ref_2    <= '0;
			o_snap_is_range <= 1'b0;
		end else begin
			r_run_d <= i_run;
			if (i_run && !r_run_d) begin
				o_snap_oper_1   <= o_oper_1;
				o_snap_ref_1    <= o_ref_1;
				o_snap_oper_2   <= o_oper_2;
				o_snap_ref_2    <= o_ref_2;
				o_snap_is_range <= o_is_range;
			end
		end
	end

	// Writes from outside must hit a real register
	a_cfg_addr_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_cfg_we |-> (i_cfg_addr <= CFG_IS_RANGE));

endmodule

`default_nettype wire

/* src/hnet_split_1to2.sv */
`default_nettype none

module hnet_split_1to2 (
	input  wire                       i_clk,
	input  wire                       i_rst_n,
	// Incoming message
	input  wire                       i_in_req,
	input  wire [hnet_pkg::ASZ-1:0]   i_in_src,
	input  wire [hnet_pkg::ASZ-1:0]   i_in_dst,
	input  wire [hnet_pkg::DSZ-1:0]   i_in_dat,
	output logic                      o_in_ack,
	// Output 0, destinations that match
	output logic                      o_out0_req,
	output logic [hnet_pkg::ASZ-1:0]  o_out0_src,
	output logic [hnet_pkg::ASZ-1:0]  o_out0_dst,
	output logic [hnet_pkg::DSZ-1:0]  o_out0_dat,
	input  wire                       i_out0_ack,
	// Output 1, everything else
	output logic                      o_out1_req,
	output logic [hnet_pkg::ASZ-1:0]  o_out1_src,
	output logic [hnet_pkg::ASZ-1:0]  o_out1_dst,
	output logic [hnet_pkg::DSZ-1:0]  o_out1_dat,
	input  wire                       i_out1_ack,
	// Live comparison settings
	input  wire hnet_pkg::cmp_op_t    i_oper_1,
	input  wire [hnet_pkg::ASZ-1:0]   i_ref_1,
	input  wire hnet_pkg::cmp_op_t    i_oper_2,
	input  wire [hnet_pkg::ASZ-1:0]   i_ref_2,
	input  wire                       i_is_range
);
	import hnet_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_LATCH, S_SEND, S_DONE} state_t;

	state_t           r_state;
	logic             r_sel0;
	logic [ASZ-1:0]   r_src;
	logic [ASZ-1:0]   r_dst;
	logic [DSZ-1:0]   r_dat;
	logic             w_take;

	// Accept only once both outputs have finished their last exchange
	assign w_take = (r_state == S_IDLE) && i_in_req && !i_out0_ack && !i_out1_ack;

	// Message holding registers
	always_ff @(posedge i_clk) begin
		if (w_take) begin
			r_src  <= i_in_src;
			r_dst  <= i_in_dst;
			r_dat  <= i_in_dat;
			r_sel0 <= range_match(i_in_dst, i_is_range, i_oper_1, i_ref_1, i_oper_2, i_ref_2);
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			r_state    <= S_IDLE;
			o_in_ack   <= 1'b0;
			o_out0_req <= 1'b0;
			o_out1_req <= 1'b0;
		end else begin
			case (r_state)
				S_IDLE: if (w_take) r_state <= S_LATCH;
				S_LATCH: begin
					o_out0_req <= r_sel0;
					o_out1_req <= !r_sel0;
					r_state    <= S_SEND;
				end
				S_SEND: begin
					// Selected sink took it, release and ack upstream
					if ((o_out0_req && i_out0_ack) || (o_out1_req && i_out1_ack)) begin
						o_out0_req <= 1'b0;
						o_out1_req <= 1'b0;
						o_in_ack   <= 1'b1;
						r_state    <= S_DONE;
					end
				end
				S_DONE: begin
					if (!i_in_req) begin
						o_in_ack <= 1'b0;
						r_state  <= S_IDLE;
					end
				end
				default: r_state <= S_IDLE;
			endcase
		end
	end

	// Both sides show the same fields; only req tells them apart
	assign o_out0_src = r_src;
	assign o_out0_dst = r_dst;
	assign o_out0_dat = r_dat;
	assign o_out1_src = r_src;
	assign o_out1_dst = r_dst;
	assign o_out1_dat = r_dat;

	a_one_output: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(o_out0_req && o_out1_req));

	// Sender must hold its fields until we ack
	a_in_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_in_req && !o_in_ack) |=>
			(i_in_req && $stable(i_in_src) && $stable(i_in_dst) && $stable(i_in_dat)));

endmodule

`default_nettype wire

/* src/hnet_top.sv */
`default_nettype none

module hnet_top #(
	parameter logic [hnet_pkg::ASZ-1:0] MIN_ADDR = 8'd1,
	parameter logic [hnet_pkg::ASZ-1:0] MAX_ADDR = 8'd15
) (
	input  wire                        i_clk,
	input  wire                        i_rst_n,
	input  wire                        i_run,
	input  wire                        i_cfg_we,
	input  wire [hnet_pkg::CFG_AW-1:0] i_cfg_addr,
	input  wire [hnet_pkg::ASZ-1:0]    i_cfg_wdata,
	output wire [hnet_pkg::DSZ-1:0]    o_0_ck_dat,
	output wire                        o_0_err,
	output wire [hnet_pkg::DSZ-1:0]    o_1_ck_dat,
	output wire                        o_1_err
);
	import hnet_pkg::*;

	// Live and snapshot settings
	cmp_op_t         oper_1, oper_2, snap_oper_1, snap_oper_2;
	logic [ASZ-1:0]  ref_1, ref_2, snap_ref_1, snap_ref_2;
	logic            is_range, snap_is_range;

	// Source to splitter
	logic            in_req, in_ack;
	logic [ASZ-1:0]  in_src, in_dst;
	logic [DSZ-1:0]  in_dat;

	// Splitter to sinks
	logic            out0_req, out0_ack, out1_req, out1_ack;
	logic [ASZ-1:0]  out0_src, out0_dst, out1_src, out1_dst;
	logic [DSZ-1:0]  out0_dat, out1_dat;

	hnet_range_cfg u_cfg (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_cfg_we(i_cfg_we), .i_cfg_addr(i_cfg_addr),
		.i_cfg_wdata(i_cfg_wdata), .i_run(i_run),
		.o_oper_1(oper_1), .o_ref_1(ref_1), .o_oper_2(oper_2), .o_ref_2(ref_2),
		.o_is_range(is_range),
		.o_snap_oper_1(snap_oper_1), .o_snap_ref_1(snap_ref_1),
		.o_snap_oper_2(snap_oper_2), .o_snap_ref_2(snap_ref_2),
		.o_snap_is_range(snap_is_range)
	);

	hnet_split_1to2 u_split (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_in_req(in_req), .i_in_src(in_src), .i_in_dst(in_dst), .i_in_dat(in_dat),
		.o_in_ack(in_ack),
		.o_out0_req(out0_req), .o_out0_src(out0_src), .o_out0_dst(out0_dst),
		.o_out0_dat(out0_dat), .i_out0_ack(out0_ack),
		.o_out1_req(out1_req), .o_out1_src(out1_src), .o_out1_dst(out1_dst),
		.o_out1_dat(out1_dat), .i_out1_ack(out1_ack),
		.i_oper_1(oper_1), .i_ref_1(ref_1), .i_oper_2(oper_2), .i_ref_2(ref_2),
		.i_is_range(is_range)
	);

	hnet_traffic_1to2 #(.MIN_ADDR(MIN_ADDR), .MAX_ADDR(MAX_ADDR)) u_traffic (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_run(i_run),
		.o_src_req(in_req), .o_src_src(in_src), .o_src_dst(in_dst), .o_src_dat(in_dat),
		.i_src_ack(in_ack),
		.i_snk0_req(out0_req), .i_snk0_src(out0_src), .i_snk0_dst(out0_dst),
		.i_snk0_dat(out0_dat), .o_snk0_ack(out0_ack),
		.i_snk1_req(out1_req), .i_snk1_src(out1_src), .i_snk1_dst(out1_dst),
		.i_snk1_dat(out1_dat), .o_snk1_ack(out1_ack),
		.i_snap_oper_1(snap_oper_1), .i_snap_ref_1(snap_ref_1),
		.i_snap_oper_2(snap_oper_2), .i_snap_ref_2(snap_ref_2),
		.i_snap_is_range(snap_is_range),
		.o_0_ck_dat(o_0_ck_dat), .o_0_err(o_0_err),
		.o_1_ck_dat(o_1_ck_dat), .o_1_err(o_1_err)
	);

endmodule

`default_nettype wire

/* src/hnet_traffic_1to2.sv */
`default_nettype none

module hnet_traffic_1to2 #(
	parameter logic [hnet_pkg::ASZ-1:0] MIN_ADDR = 8'd1,
	parameter logic [hnet_pkg::ASZ-1:0] MAX_ADDR = 8'd15
) (
	input  wire                       i_clk,
	input  wire                       i_rst_n,
	input  wire                       i_run,
	// Source side
	output logic                      o_src_req,
	output logic [hnet_pkg::ASZ-1:0]  o_src_src,
	output logic [hnet_pkg::ASZ-1:0]  o_src_dst,
	output logic [hnet_pkg::DSZ-1:0]  o_src_dat,
	input  wire                       i_src_ack,
	// Sink 0
	input  wire                       i_snk0_req,
	input  wire [hnet_pkg::ASZ-1:0]   i_snk0_src,
	input  wire [hnet_pkg::ASZ-1:0]   i_snk0_dst,
	input  wire [hnet_pkg::DSZ-1:0]   i_snk0_dat,
	output logic                      o_snk0_ack,
	// Sink 1
	input  wire                       i_snk1_req,
	input  wire [hnet_pkg::ASZ-1:0]   i_snk1_src,
	input  wire [hnet_pkg::ASZ-1:0]   i_snk1_dst,
	input  wire [hnet_pkg::DSZ-1:0]   i_snk1_dat,
	output logic                      o_snk1_ack,
	// Settings captured at run start
	input  wire hnet_pkg::cmp_op_t    i_snap_oper_1,
	input  wire [hnet_pkg::ASZ-1:0]   i_snap_ref_1,
	input  wire hnet_pkg::cmp_op_t    i_snap_oper_2,
	input  wire [hnet_pkg::ASZ-1:0]   i_snap_ref_2,
	input  wire                       i_snap_is_range,
	output logic [hnet_pkg::DSZ-1:0]  o_0_ck_dat,
	output logic                      o_0_err,
	output logic [hnet_pkg::DSZ-1:0]  o_1_ck_dat,
	output logic                      o_1_err
);
	import hnet_pkg::*;

	logic w_0_match;
	logic w_1_match;

	// Source, one message in flight
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_src_req <= 1'b0;
			o_src_dst <= MIN_ADDR;
			o_src_dat <= 16'd1;
		end else if (o_src_req) begin
			if (i_src_ack) begin
				o_src_req <= 1'b0;
				o_src_dst <= (o_src_dst >= MAX_ADDR) ? MIN_ADDR : o_src_dst + 1'b1;
				o_src_dat <= o_src_dat + 1'b1;
			end
		end else if (i_run && !i_src_ack) begin
			o_src_req <= 1'b1;
		end
	end

	assign o_src_src = '0;

	assign w_0_match = range_match(i_snk0_dst, i_snap_is_range, i_snap_oper_1, i_snap_ref_1,
		i_snap_oper_2, i_snap_ref_2);
	assign w_1_match = range_match(i_snk1_dst, i_snap_is_range, i_snap_oper_1, i_snap_ref_1,
		i_snap_oper_2, i_snap_ref_2);

	// Sink 0 wants matching destinations
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_snk0_ack <= 1'b0;
			o_0_ck_dat <= '0;
			o_0_err    <= 1'b0;
		end else if (i_snk0_req && !o_snk0_ack) begin
			// Ack even a bad message so traffic keeps moving
			o_snk0_ack <= 1'b1;
			if (!w_0_match || (i_snk0_src != '0))
				o_0_err <= 1'b1;
			else
				o_0_ck_dat <= i_snk0_dat;
		end else if (!i_snk0_req && o_snk0_ack) begin
			o_snk0_ack <= 1'b0;
		end
	end

	// Sink 1 wants the rest
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_snk1_ack <= 1'b0;
			o_1_ck_dat <= '0;
			o_1_err    <= 1'b0;
		end else if (i_snk1_req && !o_snk1_ack) begin
			o_snk1_ack <= 1'b1;
			if (w_1_match || (i_snk1_src != '0))
				o_1_err <= 1'b1;
			else
				o_1_ck_dat <= i_snk1_dat;
		end else if (!i_snk1_req && o_snk1_ack) begin
			o_snk1_ack <= 1'b0;
		end
	end

	a_addr_order: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		MIN_ADDR <= MAX_ADDR);

endmodule

`default_nettype wire

/* verification/hnet_tb.sv */
`default_nettype none

module hnet_tb;
	localparam logic [7:0] MIN_ADDR = 8'd2;
	localparam logic [7:0] MAX_ADDR = 8'd13;
	localparam int MAX_TESTS = 32;

	wire        clk;
	wire        rst_n;
	wire [15:0] ck_dat_0;
	wire [15:0] ck_dat_1;
	wire        err_0;
	wire        err_1;
	logic       rst_req;
	logic       run;
	logic       cfg_we;
	logic [2:0] cfg_addr;
	logic [7:0] cfg_wdata;
	logic       chk_begin;
	logic       chk_end;
	logic       chk_last;
	logic       skip_ok;
	logic [2:0] op_1;
	logic [2:0] op_2;
	logic [7:0] ref_1;
	logic [7:0] ref_2;
	logic       is_range;
	logic [1:0] exp_err;
	int         seen;
	int         errors;
	int         n_tests;
	int         bad_lines;
	int         limit;

	// Columns: op_1 ref_1 op_2 ref_2 is_range count rewrite_at rewrite_addr rewrite_data exp_err
	string      names[MAX_TESTS];
	int         cols[MAX_TESTS][10];

	hnet_tb_clock u_clock (.i_rst_req(rst_req), .o_clk(clk), .o_rst_n(rst_n));

	hnet_top #(.MIN_ADDR(MIN_ADDR), .MAX_ADDR(MAX_ADDR)) uut (
		.i_clk(clk), .i_rst_n(rst_n), .i_run(run),
		.i_cfg_we(cfg_we), .i_cfg_addr(cfg_addr), .i_cfg_wdata(cfg_wdata),
		.o_0_ck_dat(ck_dat_0), .o_0_err(err_0), .o_1_ck_dat(ck_dat_1), .o_1_err(err_1)
	);

	hnet_tb_checker #(.MIN_ADDR(MIN_ADDR), .MAX_ADDR(MAX_ADDR)) u_chk (
		.i_clk(clk), .i_rst_n(rst_n), .i_begin(chk_begin), .i_end(chk_end),
		.i_last(chk_last), .i_skip_ok(skip_ok),
		.i_op_1(op_1), .i_ref_1(ref_1), .i_op_2(op_2), .i_ref_2(ref_2),
		.i_is_range(is_range), .i_exp_err(exp_err),
		.i_0_ck_dat(ck_dat_0), .i_0_err(err_0), .i_1_ck_dat(ck_dat_1), .i_1_err(err_1),
		.o_seen(seen), .o_errors(errors)
	);

	task automatic load_tests(input int fd);
		string line;
		string name;
		int rc;
		int n;
		rc = $fgets(line, fd);
		while (rc > 0 && n_tests < MAX_TESTS) begin
			if (line.len() > 1 && line.getc(0) != "#") begin
				n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d", name,
					cols[n_tests][0], cols[n_tests][1], cols[n_tests][2], cols[n_tests][3],
					cols[n_tests][4], cols[n_tests][5], cols[n_tests][6], cols[n_tests][7],
					cols[n_tests][8], cols[n_tests][9]);
				if (n == 11) begin
					names[n_tests] = name;
					n_tests++;
				end else begin
					$display("Malformed line in test file: %s", line);
					bad_lines++;
				end
			end
			rc = $fgets(line, fd);
		end
	endtask

	// Called on a falling edge, returns on the next one
	task automatic write_reg(input logic [2:0] addr, input logic [7:0] data);
		cfg_we = 1'b1;
		cfg_addr = addr;
		cfg_wdata = data;
		@(negedge clk);
		cfg_we = 1'b0;
	endtask

	task automatic wait_seen(input int n);
		while (seen < n)
			@(negedge clk);
	endtask

	task automatic run_test(input int t);
		$display("Test %0d: %s", t + 1, names[t]);
		@(negedge clk);
		op_1 = 3'(cols[t][0]);
		ref_1 = 8'(cols[t][1]);
		op_2 = 3'(cols[t][2]);
		ref_2 = 8'(cols[t][3]);
		is_range = 1'(cols[t][4]);
		exp_err = 2'(cols[t][9]);
		skip_ok = 1'b0;
		// Errors are sticky, so every test starts from reset
		rst_req = 1'b1;
		@(posedge rst_n);
		@(negedge clk);
		rst_req = 1'b0;
		chk_begin = 1'b1;
		@(negedge clk);
		chk_begin = 1'b0;
		write_reg(hnet_pkg::CFG_OPER_1, 8'(op_1));
		write_reg(hnet_pkg::CFG_REF_1, ref_1);
		write_reg(hnet_pkg::CFG_OPER_2, 8'(op_2));
		write_reg(hnet_pkg::CFG_REF_2, ref_2);
		write_reg(hnet_pkg::CFG_IS_RANGE, 8'(is_range));
		run = 1'b1;
		if (cols[t][6] > 0) begin
			wait_seen(cols[t][6]);
			write_reg(3'(cols[t][7]), 8'(cols[t][8]));
			skip_ok = 1'b1;
		end
		wait_seen(cols[t][5]);
		run = 1'b0;
		// Let the message in flight finish
		@(negedge clk);
		while (uut.in_req || uut.in_ack)
			@(negedge clk);
		chk_end = 1'b1;
		chk_last = (t == n_tests - 1);
		@(negedge clk);
		chk_end = 1'b0;
	endtask

	initial begin
		int fd;
		int total;
		int t;
		rst_req = 1'b0;
		run = 1'b0;
		cfg_we = 1'b0;
		cfg_addr = 3'd0;
		cfg_wdata = 8'd0;
		chk_begin = 1'b0;
		chk_end = 1'b0;
		chk_last = 1'b0;
		skip_ok = 1'b0;
		op_1 = 3'd0;
		op_2 = 3'd0;
		ref_1 = 8'd0;
		ref_2 = 8'd0;
		is_range = 1'b0;
		exp_err = 2'd0;
		fd = $fopen("verification/hnet_tests.txt", "r");
		if (fd == 0) begin
			$display("Could not open verification/hnet_tests.txt");
			$display("Done: errors found");
			$finish;
		end else begin
			load_tests(fd);
			$fclose(fd);
			total = 0;
			for (t = 0; t < n_tests; t++)
				total += cols[t][5];
			// 20 cycles per message plus reset and setup per test
			limit = total * 20 + n_tests * 60 + 20;
			for (t = 0; t < n_tests; t++)
				run_test(t);
			@(negedge clk);
			if (n_tests == 0)
				$display("No tests were read from the test file");
			if (errors == 0 && n_tests > 0 && bad_lines == 0)
				$display("Done: no errors");
			else
				$display("Done: errors found");
			$finish;
		end
	end

	// Watchdog
	initial begin
		wait (limit > 0);
		repeat (limit) @(posedge clk);
		$display("Timeout: tests did not finish within %0d cycles", limit);
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/hnet_tb_checker.sv */
`default_nettype none

module hnet_tb_checker #(
	parameter logic [7:0] MIN_ADDR = 8'd1,
	parameter logic [7:0] MAX_ADDR = 8'd15
) (
	input  wire        i_clk,
	input  wire        i_rst_n,
	input  wire        i_begin,
	input  wire        i_end,
	input  wire        i_last,
	input  wire        i_skip_ok,
	input  wire [2:0]  i_op_1,
	input  wire [7:0]  i_ref_1,
	input  wire [2:0]  i_op_2,
	input  wire [7:0]  i_ref_2,
	input  wire        i_is_range,
	input  wire [1:0]  i_exp_err,
	input  wire [15:0] i_0_ck_dat,
	input  wire        i_0_err,
	input  wire [15:0] i_1_ck_dat,
	input  wire        i_1_err,
	output int         o_seen,
	output int         o_errors
);
	int          tests;
	int          failed;
	int          errs_at_begin;
	int          last;
	bit          active;
	logic [15:0] prev_0;
	logic [15:0] prev_1;

	// Operator codes 0 eq, 1 ne, 2 gt, 3 ge, 4 lt, 5 le
	function automatic bit holds(input int op, input int a, input int r);
		case (op)
			0: return a == r;
			1: return a != r;
			2: return a > r;
			3: return a >= r;
			4: return a < r;
			5: return a <= r;
			default: return 1'b0;
		endcase
	endfunction

	// Sink that data word k belongs to under the settings at run start
	function automatic int sink_for(input int k);
		int dst;
		dst = int'(MIN_ADDR) + (k - 1) % (int'(MAX_ADDR) - int'(MIN_ADDR) + 1);
		if (holds(int'(i_op_1), dst, int'(i_ref_1)) &&
				(!i_is_range || holds(int'(i_op_2), dst, int'(i_ref_2))))
			return 0;
		return 1;
	endfunction

	task automatic report(input string msg);
		$display("%s", msg);
		o_errors++;
	endtask

	task automatic start_test();
		tests++;
		errs_at_begin = o_errors;
		o_seen = 0;
		last = 0;
		active = 1'b1;
		// Fresh reset state
		if (i_0_ck_dat != 16'd0)
			report($sformatf("ERROR t=%0t o_0_ck_dat: got %0d, expected 0", $time, i_0_ck_dat));
		if (i_1_ck_dat != 16'd0)
			report($sformatf("ERROR t=%0t o_1_ck_dat: got %0d, expected 0", $time, i_1_ck_dat));
		if (i_0_err)
			report($sformatf("ERROR t=%0t o_0_err: got %0b, expected 0", $time, i_0_err));
		if (i_1_err)
			report($sformatf("ERROR t=%0t o_1_err: got %0b, expected 0", $time, i_1_err));
	endtask

	task automatic check_word(input int sink, input int v);
		int want;
		want = sink_for(v);
		if (want != sink)
			report($sformatf("ERROR t=%0t o_%0d_ck_dat: data %0d on sink %0d, expected sink %0d",
				$time, sink, v, sink, want));
		if (!i_skip_ok && v != last + 1)
			report($sformatf("ERROR t=%0t o_%0d_ck_dat: got %0d, expected %0d",
				$time, sink, v, last + 1));
		else if (i_skip_ok && v <= last)
			report($sformatf("ERROR t=%0t o_%0d_ck_dat: got %0d, expected above %0d",
				$time, sink, v, last));
		last = v;
		o_seen++;
	endtask

	task automatic finish_test();
		int k;
		int exp_0;
		int exp_1;
		if (i_0_err != i_exp_err[0])
			report($sformatf("ERROR t=%0t o_0_err: got %0b, expected %0b",
				$time, i_0_err, i_exp_err[0]));
		if (i_1_err != i_exp_err[1])
			report($sformatf("ERROR t=%0t o_1_err: got %0b, expected %0b",
				$time, i_1_err, i_exp_err[1]));
		// Without a rewrite every word landed and the final values are known
		if (!i_skip_ok) begin
			exp_0 = 0;
			exp_1 = 0;
			for (k = 1; k <= o_seen; k++) begin
				if (sink_for(k) == 0)
					exp_0 = k;
				else
					exp_1 = k;
			end
			if (int'(i_0_ck_dat) != exp_0)
				report($sformatf("ERROR t=%0t o_0_ck_dat: got %0d, expected %0d",
					$time, i_0_ck_dat, exp_0));
			if (int'(i_1_ck_dat) != exp_1)
				report($sformatf("ERROR t=%0t o_1_ck_dat: got %0d, expected %0d",
					$time, i_1_ck_dat, exp_1));
		end
		active = 1'b0;
		if (o_errors == errs_at_begin) begin
			$display("Test %0d passed, %0d words checked", tests, o_seen);
		end else begin
			$display("Test %0d failed with %0d errors", tests, o_errors - errs_at_begin);
			failed++;
		end
		if (i_last)
			$display("Tests run: %0d, failed: %0d, errors: %0d", tests, failed, o_errors);
	endtask

	always @(posedge i_clk) begin
		if (i_begin) begin
			start_test();
		end else if (active && i_rst_n) begin
			if (i_0_ck_dat != prev_0)
				check_word(0, int'(i_0_ck_dat));
			if (i_1_ck_dat != prev_1)
				check_word(1, int'(i_1_ck_dat));
			if (i_end)
				finish_test();
		end
		prev_0 = i_0_ck_dat;
		prev_1 = i_1_ck_dat;
	end

endmodule

`default_nettype wire

/* verification/hnet_tb_clock.sv */
`default_nettype none

module hnet_tb_clock (
	input  wire  i_rst_req,
	output logic o_clk,
	output logic o_rst_n
);
	initial begin
		o_clk = 1'b0;
		o_rst_n = 1'b0;
	end

	// 8 unit period
	always #4 o_clk = ~o_clk;

	// Each request holds reset low for 10 cycles, released on a falling edge
	always @(posedge i_rst_req) begin
		o_rst_n = 1'b0;
		repeat (10) @(negedge o_clk);
		o_rst_n = 1'b1;
	end

endmodule

`default_nettype wire

/* verification/hnet_tests.txt */
# name op_1 ref_1 op_2 ref_2 is_range count rewrite_at rewrite_addr rewrite_data exp_err
# ops 0 eq 1 ne 2 gt 3 ge 4 lt 5 le; rewrite_at 0 is none; exp_err bit 0 sink 0, bit 1 sink 1
gt_single    2 7  0 0  0 30 0 0 0  0
range_ge_le  3 4  5 9  1 30 0 0 0  0
range_gt_lt  2 3  4 11 1 24 0 0 0  0
eq_single    0 5  0 0  0 24 0 0 0  0
ne_range     1 6  1 8  1 24 0 0 0  0
le_single    5 6  0 0  0 20 0 0 0  0
all_to_0     3 0  0 0  0 36 0 0 0  0
all_to_1     4 2  0 0  0 36 0 0 0  0
rewrite_ref  2 7  0 0  0 30 6 1 10 2
rewrite_op   4 5  0 0  0 5  4 0 2  3
